// File: hdl/thumb_isa_pkg.sv
package thumb_isa_pkg;

    // direction bit shared by single and multiple load/store forms
    localparam int L_BIT = 11;

    // base register field of STM/LDM
    localparam int BASE_LSB = 8;
    localparam int BASE_W = 3;

    // sub-opcode field positions inside the instruction
    localparam int SHIFT_OP_LSB = 11;
    localparam int IMM8_OP_LSB = 11;
    localparam int ADDSUB_IMM_BIT = 10;
    localparam int ADDSUB_SUB_BIT = 9;
    localparam int DP_SEL_BIT = 10;
    localparam int DP_OP_LSB = 6;

    typedef struct packed {
        logic [4:0]  op;
        logic [10:0] body;
    } instr_t;

    // each value is the lowest encoding of its group
    typedef enum logic [4:0] {
        OP_SHIFT_IMM = 5'b00000,
        OP_ADD_SUB   = 5'b00011,
        OP_IMM8      = 5'b00100,
        OP_DATA_PROC = 5'b01000,
        OP_LS_REG    = 5'b01010,
        OP_LS_IMM    = 5'b01100,
        OP_STM       = 5'b11000,
        OP_LDM       = 5'b11001,
        OP_UNKNOWN   = 5'b11111
    } major_op_e;

    typedef enum logic [1:0] {SH_LSL, SH_LSR, SH_ASR} shift_op_e;

    typedef enum logic [1:0] {IMM8_MOV, IMM8_CMP, IMM8_ADD, IMM8_SUB} imm8_op_e;

    typedef enum logic [3:0] {
        DP_AND, DP_EOR, DP_LSL, DP_LSR, DP_ASR, DP_ADC, DP_SBC, DP_ROR,
        DP_TST, DP_RSB, DP_CMP, DP_CMN, DP_ORR, DP_MUL, DP_BIC, DP_MVN
    } dp_op_e;

    // 00011 must be matched before the wider 000xx shift pattern
    function automatic major_op_e decode_major(input instr_t instr);
        major_op_e major;
        casez (instr.op)
            5'b00011: major = OP_ADD_SUB;
            5'b000??: major = OP_SHIFT_IMM;
            5'b001??: major = OP_IMM8;
            5'b01000: major = instr[DP_SEL_BIT] ? OP_UNKNOWN : OP_DATA_PROC;
            5'b0101?: major = OP_LS_REG;
            5'b011??: major = OP_LS_IMM;
            5'b11000: major = OP_STM;
            5'b11001: major = OP_LDM;
            default:  major = OP_UNKNOWN;
        endcase
        return major;
    endfunction

endpackage

// File: hdl/ctrl_sig_pkg.sv
package ctrl_sig_pkg;

    localparam int WORD_W = 32;
    localparam int REG_ADDR_W = 4;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_ADC, ALU_SBC,
        ALU_AND, ALU_OR, ALU_XOR, ALU_BIC, ALU_NOT,
        ALU_LSL, ALU_LSR, ALU_ASR, ALU_ROR, ALU_MUL
    } alu_op_e;

    typedef enum logic {A_FROM_REG, A_FROM_ZERO} src_a_e;

    // offset comes from the multi-register transfer counter
    typedef enum logic [1:0] {B_FROM_REG, B_FROM_IMM, B_FROM_OFFSET} src_b_e;

    typedef enum logic {WB_FROM_ALU, WB_FROM_MEM} wb_src_e;

    typedef struct packed {
        logic    valid;
        logic    update_flags;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        wb_src_e wb_src;
        src_a_e  src_a;
        src_b_e  src_b;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic                  stall;
        // register port 2 address is taken from reg_addr
        logic                  read_addr_override;
        // destination address is taken from reg_addr
        logic                  dest_addr_override;
        logic [REG_ADDR_W-1:0] reg_addr;
        logic [WORD_W-1:0]     offset;
    } xfer_t;

    typedef enum logic {SEQ_IDLE, SEQ_XFER} seq_state_e;

    // a bubble, nothing is enabled
    localparam ctrl_t CTRL_NOP = '{
        valid:        1'b0,
        update_flags: 1'b0,
        reg_write:    1'b0,
        mem_read:     1'b0,
        mem_write:    1'b0,
        wb_src:       WB_FROM_ALU,
        src_a:        A_FROM_REG,
        src_b:        B_FROM_REG,
        alu_op:       ALU_ADD
    };

    localparam xfer_t XFER_NONE = '{default: '0};

endpackage

// File: hdl/single_cycle_decoder.sv
module single_cycle_decoder (
    input  thumb_isa_pkg::instr_t instruction_i,
    output ctrl_sig_pkg::ctrl_t   dec_ctrl_o
);
    import thumb_isa_pkg::*;
    import ctrl_sig_pkg::*;

    major_op_e major;
    shift_op_e shift_op;
    imm8_op_e  imm8_op;
    dp_op_e    dp_op;

    assign major = decode_major(instruction_i);
    assign shift_op = shift_op_e'(instruction_i[SHIFT_OP_LSB +: 2]);
    assign imm8_op = imm8_op_e'(instruction_i[IMM8_OP_LSB +: 2]);
    assign dp_op = dp_op_e'(instruction_i[DP_OP_LSB +: 4]);

    always_comb begin
        dec_ctrl_o = CTRL_NOP;
        // unknown encodings leave valid low
        dec_ctrl_o.valid = (major != OP_UNKNOWN);

        case (major)
            OP_SHIFT_IMM: begin
                dec_ctrl_o.update_flags = 1'b1;
                dec_ctrl_o.reg_write = 1'b1;
                dec_ctrl_o.src_b = B_FROM_IMM;
                case (shift_op)
                    SH_LSL:  dec_ctrl_o.alu_op = ALU_LSL;
                    SH_LSR:  dec_ctrl_o.alu_op = ALU_LSR;
                    SH_ASR:  dec_ctrl_o.alu_op = ALU_ASR;
                    default: dec_ctrl_o.alu_op = ALU_ADD;
                endcase
            end
            OP_ADD_SUB: begin
                dec_ctrl_o.update_flags = 1'b1;
                dec_ctrl_o.reg_write = 1'b1;
                dec_ctrl_o.alu_op = instruction_i[ADDSUB_SUB_BIT] ? ALU_SUB : ALU_ADD;
                dec_ctrl_o.src_b = instruction_i[ADDSUB_IMM_BIT] ? B_FROM_IMM : B_FROM_REG;
            end
            OP_IMM8: begin
                dec_ctrl_o.update_flags = 1'b1;
                dec_ctrl_o.reg_write = 1'b1;
                dec_ctrl_o.src_b = B_FROM_IMM;
                case (imm8_op)
                    // move is computed as zero plus the immediate
                    IMM8_MOV: dec_ctrl_o.src_a = A_FROM_ZERO;
                    IMM8_CMP: begin
                        dec_ctrl_o.alu_op = ALU_SUB;
                        dec_ctrl_o.reg_write = 1'b0;
                    end
                    IMM8_SUB: dec_ctrl_o.alu_op = ALU_SUB;
                    default:  dec_ctrl_o.alu_op = ALU_ADD;
                endcase
            end
            OP_DATA_PROC: begin
                dec_ctrl_o.update_flags = 1'b1;
                dec_ctrl_o.reg_write = !(dp_op inside {DP_TST, DP_CMP, DP_CMN});
                case (dp_op)
                    DP_AND, DP_TST: dec_ctrl_o.alu_op = ALU_AND;
                    DP_EOR:         dec_ctrl_o.alu_op = ALU_XOR;
                    DP_LSL:         dec_ctrl_o.alu_op = ALU_LSL;
                    DP_LSR:         dec_ctrl_o.alu_op = ALU_LSR;
                    DP_ASR:         dec_ctrl_o.alu_op = ALU_ASR;
                    DP_ADC:         dec_ctrl_o.alu_op = ALU_ADC;
                    DP_SBC:         dec_ctrl_o.alu_op = ALU_SBC;
                    DP_ROR:         dec_ctrl_o.alu_op = ALU_ROR;
                    DP_CMP:         dec_ctrl_o.alu_op = ALU_SUB;
                    DP_CMN:         dec_ctrl_o.alu_op = ALU_ADD;
                    DP_ORR:         dec_ctrl_o.alu_op = ALU_OR;
                    DP_MUL:         dec_ctrl_o.alu_op = ALU_MUL;
                    DP_BIC:         dec_ctrl_o.alu_op = ALU_BIC;
                    DP_MVN:         dec_ctrl_o.alu_op = ALU_NOT;
                    // negate, zero minus the register
                    default: begin
                        dec_ctrl_o.alu_op = ALU_SUB;
                        dec_ctrl_o.src_a = A_FROM_ZERO;
                    end
                endcase
            end
            OP_LS_REG, OP_LS_IMM: begin
                dec_ctrl_o.wb_src = WB_FROM_MEM;
                if (major == OP_LS_IMM) begin
                    dec_ctrl_o.src_b = B_FROM_IMM;
                end
                dec_ctrl_o.mem_read = instruction_i[L_BIT];
                dec_ctrl_o.reg_write = instruction_i[L_BIT];
                dec_ctrl_o.mem_write = !instruction_i[L_BIT];
            end
            // STM and LDM are shaped by the sequencer
            default: ;
        endcase
    end

endmodule

// File: hdl/reg_list_scanner.sv
module reg_list_scanner #(
    parameter int LIST_W = 8
) (
    input  logic                                clk_i,
    input  logic                                reset_i,
    input  thumb_isa_pkg::instr_t               instruction_i,
    input  logic                                advance_i,
    input  logic                                clear_i,
    output logic [ctrl_sig_pkg::REG_ADDR_W-1:0] pick_addr_o,
    output logic                                pending_o,
    output logic                                base_hit_o
);
    import thumb_isa_pkg::*;
    import ctrl_sig_pkg::*;

    // a set bit marks a register that has not been transferred yet
    logic [LIST_W-1:0] mask_q;
    logic [LIST_W-1:0] live_list;
    logic              base_hit_q;
    logic              pick_is_base;

    assign live_list = instruction_i[LIST_W-1:0] & mask_q;
    assign pending_o = |live_list;
    assign base_hit_o = base_hit_q;
    assign pick_is_base = (pick_addr_o == REG_ADDR_W'(instruction_i[BASE_LSB +: BASE_W]));

    // loads walk the list from the top, stores from the bottom
    always_comb begin
        pick_addr_o = '0;
        if (instruction_i[L_BIT]) begin
            for (int i = 0; i < LIST_W; i++) begin
                if (live_list[i]) begin
                    pick_addr_o = REG_ADDR_W'(i);
                end
            end
        end else begin
            for (int i = LIST_W - 1; i >= 0; i--) begin
                if (live_list[i]) begin
                    pick_addr_o = REG_ADDR_W'(i);
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || clear_i) begin
            mask_q <= '1;
            base_hit_q <= 1'b0;
        end else if (advance_i) begin
            mask_q <= mask_q & ~(LIST_W'(1) << pick_addr_o);
            // stays set until the writeback clears it
            if (pick_is_base) begin
                base_hit_q <= 1'b1;
            end
        end
    end

endmodule

// File: hdl/transfer_offset_gen.sv
module transfer_offset_gen #(
    parameter int LIST_W = 8
) (
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  thumb_isa_pkg::instr_t           instruction_i,
    input  logic                            advance_i,
    input  logic                            clear_i,
    input  logic                            wb_phase_i,
    output logic [ctrl_sig_pkg::WORD_W-1:0] offset_o
);
    import thumb_isa_pkg::*;
    import ctrl_sig_pkg::*;

    localparam int CNT_W = $clog2(LIST_W + 1);

    logic [CNT_W-1:0] xfer_cnt_q;
    logic [CNT_W-1:0] list_cnt;
    logic [CNT_W-1:0] step;

    always_comb begin
        list_cnt = '0;
        for (int i = 0; i < LIST_W; i++) begin
            list_cnt = list_cnt + CNT_W'(instruction_i[i]);
        end
    end

    // loads fill from the highest word down, so their step counts backwards
    always_comb begin
        if (wb_phase_i) begin
            step = list_cnt;
        end else if (instruction_i[L_BIT]) begin
            step = list_cnt - CNT_W'(1) - xfer_cnt_q;
        end else begin
            step = xfer_cnt_q;
        end
    end

    assign offset_o = WORD_W'(step) << 2;

    always_ff @(posedge clk_i) begin
        if (reset_i || clear_i) begin
            xfer_cnt_q <= '0;
        end else if (advance_i) begin
            xfer_cnt_q <= xfer_cnt_q + CNT_W'(1);
        end
    end

endmodule

// File: hdl/ldm_stm_sequencer.sv
module ldm_stm_sequencer (
    input  logic                                clk_i,
    input  logic                                reset_i,
    input  logic                                valid_i,
    input  thumb_isa_pkg::instr_t               instruction_i,
    input  ctrl_sig_pkg::ctrl_t                 dec_ctrl_i,
    input  logic [ctrl_sig_pkg::REG_ADDR_W-1:0] pick_addr_i,
    input  logic                                pending_i,
    input  logic                                base_hit_i,
    input  logic [ctrl_sig_pkg::WORD_W-1:0]     offset_i,
    output logic                                scan_advance_o,
    output logic                                scan_clear_o,
    output logic                                wb_phase_o,
    output ctrl_sig_pkg::ctrl_t                 ctrl_o,
    output ctrl_sig_pkg::xfer_t                 xfer_o
);
    import thumb_isa_pkg::*;
    import ctrl_sig_pkg::*;

    seq_state_e state_q;
    seq_state_e state_d;
    major_op_e  major;
    logic       is_multi;
    logic       is_load;
    logic       do_xfer;
    logic       do_wb;

    assign major = decode_major(instruction_i);
    assign is_multi = (major == OP_STM) || (major == OP_LDM);
    assign is_load = instruction_i[L_BIT];

    // the pipeline holds the instruction while stalled, so XFER trusts it is still STM/LDM
    always_comb begin
        state_d = state_q;
        do_xfer = 1'b0;
        do_wb = 1'b0;
        if (!valid_i) begin
            state_d = SEQ_IDLE;
        end else if (state_q == SEQ_IDLE) begin
            if (is_multi && pending_i) begin
                do_xfer = 1'b1;
                state_d = SEQ_XFER;
            end else if (is_multi) begin
                // empty list goes straight to the base update
                do_wb = 1'b1;
            end
        end else if (pending_i) begin
            do_xfer = 1'b1;
        end else begin
            do_wb = 1'b1;
            state_d = SEQ_IDLE;
        end
    end

    always_comb begin
        ctrl_o = CTRL_NOP;
        xfer_o = XFER_NONE;
        scan_advance_o = do_xfer;
        scan_clear_o = do_wb || !valid_i;
        wb_phase_o = do_wb;

        if (do_xfer) begin
            ctrl_o.valid = 1'b1;
            ctrl_o.src_b = B_FROM_OFFSET;
            xfer_o.stall = 1'b1;
            xfer_o.reg_addr = pick_addr_i;
            xfer_o.offset = offset_i;
            if (is_load) begin
                ctrl_o.mem_read = 1'b1;
                ctrl_o.reg_write = 1'b1;
                ctrl_o.wb_src = WB_FROM_MEM;
                xfer_o.dest_addr_override = 1'b1;
            end else begin
                ctrl_o.mem_write = 1'b1;
                xfer_o.read_addr_override = 1'b1;
            end
        end else if (do_wb) begin
            // base plus 4n, skipped when an LDM already loaded the base
            ctrl_o.valid = 1'b1;
            ctrl_o.reg_write = !(is_load && base_hit_i);
            ctrl_o.src_b = B_FROM_OFFSET;
            ctrl_o.alu_op = ALU_ADD;
            ctrl_o.wb_src = WB_FROM_ALU;
            xfer_o.dest_addr_override = 1'b1;
            xfer_o.reg_addr = REG_ADDR_W'(instruction_i[BASE_LSB +: BASE_W]);
            xfer_o.offset = offset_i;
        end else if (valid_i) begin
            ctrl_o = dec_ctrl_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= SEQ_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// File: hdl/thumb_ctrl_top.sv
module thumb_ctrl_top #(
    parameter int LIST_W = 8
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  valid_i,
    input  thumb_isa_pkg::instr_t instruction_i,
    output ctrl_sig_pkg::ctrl_t   ctrl_o,
    output ctrl_sig_pkg::xfer_t   xfer_o
);
    import ctrl_sig_pkg::*;

    ctrl_t                 dec_ctrl;
    logic                  scan_advance;
    logic                  scan_clear;
    logic                  wb_phase;
    logic [REG_ADDR_W-1:0] pick_addr;
    logic                  pending;
    logic                  base_hit;
    logic [WORD_W-1:0]     offset;

    single_cycle_decoder u_decoder (
        .instruction_i (instruction_i),
        .dec_ctrl_o    (dec_ctrl)
    );

    reg_list_scanner #(
        .LIST_W (LIST_W)
    ) u_scanner (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .instruction_i (instruction_i),
        .advance_i     (scan_advance),
        .clear_i       (scan_clear),
        .pick_addr_o   (pick_addr),
        .pending_o     (pending),
        .base_hit_o    (base_hit)
    );

    transfer_offset_gen #(
        .LIST_W (LIST_W)
    ) u_offset_gen (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .instruction_i (instruction_i),
        .advance_i     (scan_advance),
        .clear_i       (scan_clear),
        .wb_phase_i    (wb_phase),
        .offset_o      (offset)
    );

    ldm_stm_sequencer u_sequencer (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .valid_i        (valid_i),
        .instruction_i  (instruction_i),
        .dec_ctrl_i     (dec_ctrl),
        .pick_addr_i    (pick_addr),
        .pending_i      (pending),
        .base_hit_i     (base_hit),
        .offset_i       (offset),
        .scan_advance_o (scan_advance),
        .scan_clear_o   (scan_clear),
        .wb_phase_o     (wb_phase),
        .ctrl_o         (ctrl_o),
        .xfer_o         (xfer_o)
    );

endmodule

// File: tests/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // reset covers three rising edges and drops on a falling edge
    initial begin
        reset_o = 1'b1;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule

// File: tests/thumb_ctrl_checker.sv
module thumb_ctrl_checker #(
    parameter int MAX_STALL = 8
) (
    input logic                clk_i,
    input logic                reset_i,
    input logic                valid_i,
    input logic                stall_i,
    input logic                clear_i,
    input logic                wb_phase_i,
    input ctrl_sig_pkg::ctrl_t ctrl_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0;

    // a full register list stalls MAX_STALL cycles and then must release
    stall_bounded: assert property (@(posedge clk_i) disable iff (reset_i)
        stall_i [*MAX_STALL] |=> !stall_i)
    else begin
        $error("stall held for more than %0d cycles", MAX_STALL);
        fail_cnt++;
    end

    // the cycle that ends a stall is the base writeback, and it resets the list state
    wb_after_stall: assert property (@(posedge clk_i) disable iff (reset_i)
        (stall_i ##1 (valid_i && !stall_i)) |-> (wb_phase_i && clear_i))
    else begin
        $error("stall ended without a writeback cycle that clears the list");
        fail_cnt++;
    end

    idle_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
        !valid_i |-> !(ctrl_i.valid || ctrl_i.reg_write || ctrl_i.mem_read
                       || ctrl_i.mem_write || stall_i))
    else begin
        $error("enable or stall set while valid_i is low");
        fail_cnt++;
    end

endmodule

// File: tests/ctrl_model_monitor.sv
module ctrl_model_monitor #(
    parameter int LIST_W = 8
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  valid_i,
    input  thumb_isa_pkg::instr_t instruction_i,
    input  ctrl_sig_pkg::ctrl_t   ctrl_i,
    input  ctrl_sig_pkg::xfer_t   xfer_i,
    output int                    check_cnt_o,
    output int                    ctrl_err_cnt_o,
    output int                    xfer_err_cnt_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import ctrl_sig_pkg::*;

    int step_q = 0;
    int checks = 0;
    int ctrl_errs = 0;
    int xfer_errs = 0;

    assign check_cnt_o = checks;
    assign ctrl_err_cnt_o = ctrl_errs;
    assign xfer_err_cnt_o = xfer_errs;

    // control word of any instruction that finishes in one cycle
    function automatic ctrl_t expect_single(input logic [15:0] ins);
        ctrl_t c;
        logic [4:0] op;
        c = '0;
        op = ins[15:11];
        if (op == 5'b00011) begin
            c = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, WB_FROM_ALU, A_FROM_REG, B_FROM_REG, ALU_ADD};
            c.alu_op = ins[9] ? ALU_SUB : ALU_ADD;
            c.src_b = ins[10] ? B_FROM_IMM : B_FROM_REG;
        end else if (op[4:2] == 3'b000) begin
            c = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, WB_FROM_ALU, A_FROM_REG, B_FROM_IMM, ALU_LSL};
            c.alu_op = (op[1:0] == 2'd0) ? ALU_LSL : (op[1:0] == 2'd1) ? ALU_LSR : ALU_ASR;
        end else if (op[4:2] == 3'b001) begin
            c = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, WB_FROM_ALU, A_FROM_REG, B_FROM_IMM, ALU_ADD};
            case (op[1:0])
                2'd0: c.src_a = A_FROM_ZERO;
                2'd1: begin
                    c.alu_op = ALU_SUB;
                    c.reg_write = 1'b0;
                end
                2'd3: c.alu_op = ALU_SUB;
                default: c.alu_op = ALU_ADD;
            endcase
        end else if (op == 5'b01000 && !ins[10]) begin
            c = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, WB_FROM_ALU, A_FROM_REG, B_FROM_REG, ALU_AND};
            case (ins[9:6])
                4'h1: c.alu_op = ALU_XOR;
                4'h2: c.alu_op = ALU_LSL;
                4'h3: c.alu_op = ALU_LSR;
                4'h4: c.alu_op = ALU_ASR;
                4'h5: c.alu_op = ALU_ADC;
                4'h6: c.alu_op = ALU_SBC;
                4'h7: c.alu_op = ALU_ROR;
                4'h8: c.reg_write = 1'b0;
                4'h9: begin
                    c.alu_op = ALU_SUB;
                    c.src_a = A_FROM_ZERO;
                end
                4'hA: begin
                    c.alu_op = ALU_SUB;
                    c.reg_write = 1'b0;
                end
                4'hB: begin
                    c.alu_op = ALU_ADD;
                    c.reg_write = 1'b0;
                end
                4'hC: c.alu_op = ALU_OR;
                4'hD: c.alu_op = ALU_MUL;
                4'hE: c.alu_op = ALU_BIC;
                4'hF: c.alu_op = ALU_NOT;
                default: c.alu_op = ALU_AND;
            endcase
        end else if (op[4:1] == 4'b0101 || op[4:2] == 3'b011) begin
            c = '{1'b1, 1'b0, ins[11], ins[11], !ins[11], WB_FROM_MEM, A_FROM_REG,
                  B_FROM_REG, ALU_ADD};
            c.src_b = (op[4:2] == 3'b011) ? B_FROM_IMM : B_FROM_REG;
        end
        return c;
    endfunction

    // k-th listed register, counted from r0 for stores and from the top for loads
    function automatic logic [3:0] nth_listed(input logic [LIST_W-1:0] list, input int k,
                                              input logic from_top);
        int seen;
        int idx;
        logic [3:0] reg_num;
        seen = 0;
        reg_num = '0;
        for (int i = 0; i < LIST_W; i++) begin
            idx = from_top ? (LIST_W - 1 - i) : i;
            if (list[idx]) begin
                if (seen == k) begin
                    reg_num = 4'(idx);
                end
                seen++;
            end
        end
        return reg_num;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp, input bit is_xfer);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
            if (is_xfer) begin
                xfer_errs++;
            end else begin
                ctrl_errs++;
            end
        end
    endtask

    always @(posedge clk_i) begin
        ctrl_t exp_c;
        xfer_t exp_x;
        logic [LIST_W-1:0] list;
        logic [2:0] base;
        logic is_load;
        int n;
        if (reset_i) begin
            step_q = 0;
        end else begin
            exp_c = '0;
            exp_x = '0;
            list = instruction_i[LIST_W-1:0];
            base = instruction_i[10:8];
            is_load = instruction_i[11];
            n = $countones(list);
            if (!valid_i) begin
                step_q = 0;
            end else if (instruction_i[15:12] == 4'b1100) begin
                exp_c.valid = 1'b1;
                exp_c.src_b = B_FROM_OFFSET;
                if (step_q < n) begin
                    exp_x.stall = 1'b1;
                    exp_x.reg_addr = nth_listed(list, step_q, is_load);
                    exp_x.offset = is_load ? 4 * (n - 1 - step_q) : 4 * step_q;
                    exp_c.mem_read = is_load;
                    exp_c.reg_write = is_load;
                    exp_c.mem_write = !is_load;
                    exp_c.wb_src = is_load ? WB_FROM_MEM : WB_FROM_ALU;
                    exp_x.dest_addr_override = is_load;
                    exp_x.read_addr_override = !is_load;
                    step_q++;
                end else begin
                    // base + 4n, dropped when a load list already holds the base
                    exp_c.reg_write = !(is_load && list[base]);
                    exp_x.dest_addr_override = 1'b1;
                    exp_x.reg_addr = {1'b0, base};
                    exp_x.offset = 4 * n;
                    step_q = 0;
                end
            end else begin
                exp_c = expect_single(instruction_i);
            end
            checks++;
            compare_field("ctrl_o.valid", ctrl_i.valid, exp_c.valid, 1'b0);
            compare_field("ctrl_o.update_flags", ctrl_i.update_flags, exp_c.update_flags, 1'b0);
            compare_field("ctrl_o.reg_write", ctrl_i.reg_write, exp_c.reg_write, 1'b0);
            compare_field("ctrl_o.mem_read", ctrl_i.mem_read, exp_c.mem_read, 1'b0);
            compare_field("ctrl_o.mem_write", ctrl_i.mem_write, exp_c.mem_write, 1'b0);
            compare_field("ctrl_o.wb_src", ctrl_i.wb_src, exp_c.wb_src, 1'b0);
            compare_field("ctrl_o.src_a", ctrl_i.src_a, exp_c.src_a, 1'b0);
            compare_field("ctrl_o.src_b", ctrl_i.src_b, exp_c.src_b, 1'b0);
            compare_field("ctrl_o.alu_op", ctrl_i.alu_op, exp_c.alu_op, 1'b0);
            compare_field("xfer_o.stall", xfer_i.stall, exp_x.stall, 1'b1);
            compare_field("xfer_o.read_addr_override", xfer_i.read_addr_override,
                          exp_x.read_addr_override, 1'b1);
            compare_field("xfer_o.dest_addr_override", xfer_i.dest_addr_override,
                          exp_x.dest_addr_override, 1'b1);
            compare_field("xfer_o.reg_addr", xfer_i.reg_addr, exp_x.reg_addr, 1'b1);
            compare_field("xfer_o.offset", xfer_i.offset, exp_x.offset, 1'b1);
        end
    end

endmodule

// File: tests/tb_thumb_ctrl.sv
module tb_thumb_ctrl;
    timeunit 1ns;
    timeprecision 1ps;
    import thumb_isa_pkg::*;
    import ctrl_sig_pkg::*;

    localparam int LIST_W = 8;
    localparam int NUM_RANDOM = 400;
    localparam logic [15:0] LFSR_SEED = 16'd80;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;

    // empty and full lists, base inside an LDM list, RSB, LDR and unknown encodings
    localparam logic [15:0] DIRECTED [10] = '{
        16'hC200, 16'hC1A6, 16'hC0FF, 16'hCB0F, 16'hCDFF,
        16'hC800, 16'h4400, 16'hE000, 16'h4240, 16'h6811
    };

    logic        clk;
    logic        reset;
    logic        valid;
    instr_t      instruction;
    ctrl_t       ctrl;
    xfer_t       xfer;
    logic [15:0] lfsr_q;
    int          timeout_cnt;
    int          check_cnt;
    int          ctrl_errs;
    int          xfer_errs;
    int          assert_errs;

    tb_clock_gen u_clock_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    thumb_ctrl_top #(
        .LIST_W (LIST_W)
    ) i_dut (
        .clk_i         (clk),
        .reset_i       (reset),
        .valid_i       (valid),
        .instruction_i (instruction),
        .ctrl_o        (ctrl),
        .xfer_o        (xfer)
    );

    ctrl_model_monitor #(
        .LIST_W (LIST_W)
    ) u_monitor (
        .clk_i          (clk),
        .reset_i        (reset),
        .valid_i        (valid),
        .instruction_i  (instruction),
        .ctrl_i         (ctrl),
        .xfer_i         (xfer),
        .check_cnt_o    (check_cnt),
        .ctrl_err_cnt_o (ctrl_errs),
        .xfer_err_cnt_o (xfer_errs)
    );

    bind ldm_stm_sequencer thumb_ctrl_checker i_checker (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .valid_i    (valid_i),
        .stall_i    (xfer_o.stall),
        .clear_i    (scan_clear_o),
        .wb_phase_i (wb_phase_o),
        .ctrl_i     (ctrl_o)
    );

    // one LFSR step per bit, the bit shifted out is the one taken
    function automatic logic [15:0] take_bits(input int count);
        logic [15:0] bits;
        logic        out_bit;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            out_bit = lfsr_q[0];
            lfsr_q = {1'b0, lfsr_q[15:1]} ^ (out_bit ? LFSR_TAPS : 16'h0000);
            bits = {bits[14:0], out_bit};
        end
        return bits;
    endfunction

    function automatic logic [15:0] random_instr();
        logic [15:0] cls;
        logic [15:0] sub;
        logic [15:0] body;
        logic [4:0]  op;
        cls = take_bits(3);
        sub = take_bits(3);
        body = take_bits(11);
        case (cls[2:0])
            3'd0: op = {3'b000, sub[1:0]};
            3'd1: op = 5'b00011;
            3'd2: op = {3'b001, sub[1:0]};
            3'd3: begin
                op = 5'b01000;
                body[10] = 1'b0;
            end
            3'd4: op = sub[2] ? {3'b011, sub[1:0]} : {4'b0101, sub[0]};
            3'd5: op = 5'b11000;
            3'd6: op = 5'b11001;
            default: op = sub[2] ? {2'b10, sub[1:0], 1'b1} : {3'b111, sub[1:0]};
        endcase
        // roughly one multi-register instruction in eight gets an empty list
        if ((cls[2:0] == 3'd5 || cls[2:0] == 3'd6) && sub[2:0] == 3'd0) begin
            body[LIST_W-1:0] = '0;
        end
        return {op, body[10:0]};
    endfunction

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (reset && cycles < 10);
        if (reset) begin
            $display("timeout: reset still asserted after %0d cycles", cycles);
            timeout_cnt++;
        end
    endtask

    // holds the instruction until a cycle with stall low has consumed it
    task automatic apply_instr(input logic [15:0] instr, input logic vld);
        int cycles;
        @(negedge clk);
        valid = vld;
        instruction = instr;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (xfer.stall && cycles <= LIST_W + 1);
        if (xfer.stall) begin
            $display("timeout: stall still high after %0d cycles for instruction %h",
                     cycles, instr);
            timeout_cnt++;
        end
    endtask

    initial begin
        logic [15:0] instr_bits;
        logic        vld_bit;
        valid = 1'b0;
        instruction = '0;
        lfsr_q = LFSR_SEED;
        timeout_cnt = 0;
        wait_reset_release();
        for (int i = 0; i < 3 && timeout_cnt == 0; i++) begin
            apply_instr(16'h0000, 1'b0);
        end
        for (int i = 0; i < 10 && timeout_cnt == 0; i++) begin
            apply_instr(DIRECTED[i], 1'b1);
        end
        for (int i = 0; i < NUM_RANDOM && timeout_cnt == 0; i++) begin
            vld_bit = (take_bits(3) != 16'd0);
            instr_bits = random_instr();
            apply_instr(instr_bits, vld_bit);
        end
        @(negedge clk);
        valid = 1'b0;
        @(posedge clk);
        // counts settle after the last rising edge has been checked
        @(negedge clk);
        assert_errs = i_dut.u_sequencer.i_checker.fail_cnt;
        $display("checks %0d, ctrl errors %0d, xfer errors %0d, assertion errors %0d, timeouts %0d",
                 check_cnt, ctrl_errs, xfer_errs, assert_errs, timeout_cnt);
        if (ctrl_errs + xfer_errs + assert_errs + timeout_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: project.f
hdl/thumb_isa_pkg.sv
hdl/ctrl_sig_pkg.sv
hdl/single_cycle_decoder.sv
hdl/reg_list_scanner.sv
hdl/transfer_offset_gen.sv
hdl/ldm_stm_sequencer.sv
hdl/thumb_ctrl_top.sv
tests/tb_clock_gen.sv
tests/thumb_ctrl_checker.sv
tests/ctrl_model_monitor.sv
tests/tb_thumb_ctrl.sv
